//--- src/ub_pkg.sv
/*
 * Useless box shared definitions
 * Modes, styles, command structs, range constants and APB register map
 */
package ub_pkg;

    // Operating modes, stepped by the mode button
    typedef enum logic [1:0] {
        MODE_NS = 2'd0,
        MODE_UB = 2'd1,
        MODE_UC = 2'd2
    } mode_t;

    // Useless box behaviour, decoded from the written style code
    typedef enum logic [1:0] {
        STYLE_CLASSIC = 2'd0,
        STYLE_DODGE   = 2'd1,
        STYLE_ADVANCE = 2'd2,
        STYLE_INVALID = 2'd3
    } ub_style_t;

    // One-hot style codes as written over APB
    localparam int STYLE_W = 3;
    localparam logic [STYLE_W-1:0] STYLE_CODE_CLASSIC = 3'b001;
    localparam logic [STYLE_W-1:0] STYLE_CODE_DODGE   = 3'b010;
    localparam logic [STYLE_W-1:0] STYLE_CODE_ADVANCE = 3'b100;

    // Range readings in cm, sum type has one spare bit
    localparam int DIST_W = 20;
    typedef logic [DIST_W-1:0] dist_t;
    typedef logic [DIST_W:0] dist_sum_t;

    // Remote drive command
    typedef struct packed {
        logic sw_toggle;
        logic fwd;
        logic back;
        logic left;
        logic right;
    } drive_cmd_t;

    typedef struct packed {
        logic l_en;
        logic l_dir;
        logic r_en;
        logic r_dir;
    } motor_drive_t;

    // Servo arm command
    localparam int AMOUNT_W = 5;
    localparam logic [AMOUNT_W-1:0] AMOUNT_MAX = 5'd31;

    typedef struct packed {
        logic                enable;
        logic                sel;
        logic [AMOUNT_W-1:0] amount;
    } servo_cmd_t;

    // Range thresholds
    localparam int GOOD_DIS   = 20;
    localparam int DELTA      = 4;
    localparam int STOP_NEAR  = GOOD_DIS / 3 + 1;
    localparam int STOP_FAR   = GOOD_DIS / 2;
    localparam int LIFT_LIMIT = 25;

    // APB register map
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;
    localparam logic [APB_AW-1:0] ADDR_STYLE  = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_DRIVE  = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h8;

    // Range 1 corrected for the asymmetric box
    function automatic dist_sum_t adj_dist(dist_t d);
        return {1'b0, d} + DIST_W'(DELTA);
    endfunction

endpackage

//--- src/debounce_filter.sv
/*
 * Debounce filter
 * Passes a payload on once it has been stable for DEB_CYCLES cycles
 */
`timescale 1ns/1ps

module debounce_filter #(
    parameter type T          = logic,
    parameter int  DEB_CYCLES = 16
) (
    input  logic clk,
    input  logic rst,
    input  T     raw,
    output T     clean
);
    localparam int CNT_W = $clog2(DEB_CYCLES + 1);

    T               raw_q;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw_q <= '0;
            cnt   <= '0;
            clean <= '0;
        end else begin
            raw_q <= raw;
            // Any change restarts the stability count
            if (raw != raw_q) begin
                cnt <= '0;
            end else if (cnt != CNT_W'(DEB_CYCLES)) begin
                cnt <= cnt + 1'b1;
            end
            // Held long enough
            if (cnt == CNT_W'(DEB_CYCLES)) begin
                clean <= raw_q;
            end
        end
    end

endmodule

//--- src/mode_fsm.sv
/*
 * Mode FSM
 * Steps NS, UB, UC on the button, holds the defended switch target, drives the relay
 */
`timescale 1ns/1ps

module mode_fsm (
    input  logic          clk,
    input  logic          rst,
    input  logic          btn,
    input  logic          toggle_req,
    input  logic          sw0,
    output ub_pkg::mode_t mode,
    output logic          sw_target,
    output logic          relay
);
    import ub_pkg::*;

    logic  btn_q;
    logic  btn_rise;
    mode_t mode_next;

    assign btn_rise = btn & ~btn_q;

    // Mode ring order
    always_comb begin
        case (mode)
            MODE_NS: mode_next = MODE_UB;
            MODE_UB: mode_next = MODE_UC;
            default: mode_next = MODE_NS;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_q <= 1'b0;
            mode  <= MODE_NS;
        end else begin
            btn_q <= btn;
            if (btn_rise) begin
                mode <= mode_next;
            end
        end
    end

    // Target starts at the switch position seen in reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sw_target <= sw0;
        end else if (toggle_req && mode == MODE_NS) begin
            sw_target <= ~sw_target;
        end
    end

    // Relay only follows the switch in NS
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            relay <= 1'b0;
        end else begin
            relay <= (mode == MODE_NS) ? sw0 : 1'b0;
        end
    end

endmodule

//--- src/apb_regs.sv
/*
 * APB register block
 * STYLE and DRIVE registers, toggle request pulse, read-only STATUS
 */
`timescale 1ns/1ps

module apb_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [ub_pkg::APB_AW-1:0] paddr,
    input  logic [ub_pkg::APB_DW-1:0] pwdata,
    output logic [ub_pkg::APB_DW-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  ub_pkg::mode_t             mode,
    input  logic                      sw_target,
    output ub_pkg::ub_style_t         style,
    output ub_pkg::drive_cmd_t        drive_cmd,
    output logic                      toggle_req
);
    import ub_pkg::*;

    logic               access;
    logic               wr_en;
    logic               addr_ok;
    logic [STYLE_W-1:0] style_code;
    drive_cmd_t         wr_drive;

    // Access phase of a transfer, never stalled
    assign access   = psel & penable;
    assign wr_en    = access & pwrite;
    assign pready   = access;
    assign wr_drive = drive_cmd_t'(pwdata[$bits(drive_cmd_t)-1:0]);

    assign addr_ok = (paddr == ADDR_STYLE) || (paddr == ADDR_DRIVE) ||
                     (paddr == ADDR_STATUS);
    // STATUS is read only
    assign pslverr = access & (~addr_ok | (pwrite & (paddr == ADDR_STATUS)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            style_code <= '0;
            drive_cmd  <= '0;
            toggle_req <= 1'b0;
        end else begin
            toggle_req <= 1'b0;
            if (wr_en && paddr == ADDR_STYLE) begin
                style_code <= pwdata[STYLE_W-1:0];
            end
            if (wr_en && paddr == ADDR_DRIVE) begin
                // Toggle bit becomes a pulse only
                drive_cmd  <= '{sw_toggle: 1'b0, fwd: wr_drive.fwd, back: wr_drive.back,
                                left: wr_drive.left, right: wr_drive.right};
                toggle_req <= wr_drive.sw_toggle;
            end
        end
    end

    // One-hot code, anything else is invalid
    always_comb begin
        case (style_code)
            STYLE_CODE_CLASSIC: style = STYLE_CLASSIC;
            STYLE_CODE_DODGE:   style = STYLE_DODGE;
            STYLE_CODE_ADVANCE: style = STYLE_ADVANCE;
            default:            style = STYLE_INVALID;
        endcase
    end

    // Readback mux
    always_comb begin
        case (paddr)
            ADDR_STYLE:  prdata = APB_DW'(style_code);
            ADDR_DRIVE:  prdata = APB_DW'(drive_cmd);
            ADDR_STATUS: prdata = APB_DW'({sw_target, mode});
            default:     prdata = '0;
        endcase
    end

endmodule

//--- src/servo_planner.sv
/*
 * Servo arm planner
 * Registered arm choice and lift amount from mode, style, switch and range
 */
`timescale 1ns/1ps

module servo_planner (
    input  logic               clk,
    input  logic               rst,
    input  ub_pkg::mode_t      mode,
    input  ub_pkg::ub_style_t  style,
    input  logic               sw0,
    input  logic               sw_target,
    input  logic [3:0]         ir_near,
    input  ub_pkg::dist_t      dist_0,
    input  ub_pkg::dist_t      dist_1,
    output ub_pkg::servo_cmd_t servo
);
    import ub_pkg::*;

    logic                ir_any;
    dist_sum_t           dist_1_adj;
    dist_sum_t           dist_near;
    logic [DIST_W+2:0]   near_x3;
    logic [AMOUNT_W-1:0] lift;
    servo_cmd_t          servo_next;

    assign ir_any     = |ir_near;
    assign dist_1_adj = adj_dist(dist_1);
    assign dist_near  = (dist_0 > dist_1_adj) ? dist_1_adj : {1'b0, dist_0};
    // Times three as x + 2x
    assign near_x3    = {2'b00, dist_near} + {1'b0, dist_near, 1'b0};

    // Closer lift, arm rises as the user approaches
    always_comb begin
        if (ir_any) begin
            lift = AMOUNT_MAX;
        end else if (dist_0 > GOOD_DIS && dist_1_adj > GOOD_DIS) begin
            lift = '0;
        end else if (near_x3 < LIFT_LIMIT) begin
            lift = near_x3[AMOUNT_W-1:0];
        end else begin
            lift = AMOUNT_MAX;
        end
    end

    always_comb begin
        servo_next = '0;
        if (sw0 != sw_target) begin
            // Switch moved away from the target
            servo_next.enable = 1'b1;
            servo_next.sel    = sw0;
            if (mode == MODE_NS) begin
                servo_next.sel    = ~sw0;
                servo_next.amount = AMOUNT_MAX;
            end else if (mode == MODE_UB &&
                         (style == STYLE_CLASSIC || style == STYLE_ADVANCE)) begin
                // Hold back while a hand is in the way
                servo_next.sel    = ~sw0;
                servo_next.amount = ir_any ? '0 : AMOUNT_MAX;
            end
        end else if (mode == MODE_UB) begin
            servo_next.enable = 1'b1;
            if (style == STYLE_ADVANCE) begin
                servo_next.sel    = ~sw0;
                servo_next.amount = lift;
            end else begin
                servo_next.sel    = sw0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            servo <= '0;
        end else begin
            servo <= servo_next;
        end
    end

endmodule

//--- src/motor_planner.sv
/*
 * Motor planner
 * Registered drive from dodge ranging in UB or remote commands in UC
 */
`timescale 1ns/1ps

module motor_planner (
    input  logic                 clk,
    input  logic                 rst,
    input  ub_pkg::mode_t        mode,
    input  ub_pkg::ub_style_t    style,
    input  ub_pkg::drive_cmd_t   drive_cmd,
    input  ub_pkg::dist_t        dist_0,
    input  ub_pkg::dist_t        dist_1,
    output ub_pkg::motor_drive_t drive
);
    import ub_pkg::*;

    dist_sum_t    dist_1_adj;
    logic         dodge_stop;
    logic         dodge_dir;
    motor_drive_t drive_next;

    assign dist_1_adj = adj_dist(dist_1);

    // Too close means already away, both far means nobody near
    assign dodge_stop = (dist_0 < STOP_NEAR) || (dist_1_adj < STOP_NEAR) ||
                        ((dist_0 > STOP_FAR) && (dist_1_adj > STOP_FAR));
    // Run away from the nearer side
    assign dodge_dir  = ~({1'b0, dist_0} > dist_1_adj);

    always_comb begin
        drive_next = '0;
        case (mode)
            MODE_UB: begin
                if (style == STYLE_DODGE && !dodge_stop) begin
                    drive_next = '{l_en: 1'b1, l_dir: dodge_dir,
                                   r_en: 1'b1, r_dir: dodge_dir};
                end
            end
            MODE_UC: begin
                // Forward wins, then back, left, right
                if (drive_cmd.fwd) begin
                    drive_next = '{l_en: 1'b1, l_dir: 1'b1, r_en: 1'b1, r_dir: 1'b1};
                end else if (drive_cmd.back) begin
                    drive_next = '{l_en: 1'b1, l_dir: 1'b0, r_en: 1'b1, r_dir: 1'b0};
                end else if (drive_cmd.left) begin
                    drive_next = '{l_en: 1'b0, l_dir: 1'b0, r_en: 1'b1, r_dir: 1'b1};
                end else if (drive_cmd.right) begin
                    drive_next = '{l_en: 1'b1, l_dir: 1'b1, r_en: 1'b0, r_dir: 1'b0};
                end
            end
            default: drive_next = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drive <= '0;
        end else begin
            drive <= drive_next;
        end
    end

endmodule

//--- src/servo_pwm.sv
/*
 * Servo PWM generator
 * Latches the arm command each period and pulses the selected channel
 */
`timescale 1ns/1ps

module servo_pwm #(
    parameter int PWM_PERIOD = 2000,
    parameter int PULSE_MIN  = 100,
    parameter int PULSE_STEP = 20
) (
    input  logic               clk,
    input  logic               rst,
    input  ub_pkg::servo_cmd_t servo,
    output logic               pwm_0,
    output logic               pwm_1
);
    import ub_pkg::*;

    // Counter wide enough for both the period and the longest pulse
    localparam int PULSE_MAX = PULSE_MIN + int'(AMOUNT_MAX) * PULSE_STEP;
    localparam int CNT_W     = $clog2((PWM_PERIOD > PULSE_MAX ? PWM_PERIOD : PULSE_MAX) + 1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] width_q;
    servo_cmd_t       cmd_q;
    logic             pulse_on;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            cmd_q   <= '0;
            width_q <= '0;
        end else if (cnt == CNT_W'(PWM_PERIOD - 1)) begin
            // New period, take the current command
            cnt     <= '0;
            cmd_q   <= servo;
            width_q <= CNT_W'(PULSE_MIN + int'(servo.amount) * PULSE_STEP);
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign pulse_on = cmd_q.enable & (cnt < width_q);
    // sel picks the arm
    assign pwm_0    = pulse_on & ~cmd_q.sel;
    assign pwm_1    = pulse_on & cmd_q.sel;

endmodule

//--- src/ub_top.sv
/*
 * Useless box controller top level
 * Input filters, mode FSM, APB registers, planners and servo PWM
 */
`timescale 1ns/1ps

module ub_top #(
    parameter int DEB_CYCLES = 16,
    parameter int PWM_PERIOD = 2000,
    parameter int PULSE_MIN  = 100,
    parameter int PULSE_STEP = 20
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mode_btn,
    input  logic                       sw0,
    input  logic [3:0]                 ir_sensor,
    input  ub_pkg::dist_t              dist_0,
    input  ub_pkg::dist_t              dist_1,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [ub_pkg::APB_AW-1:0]  paddr,
    input  logic [ub_pkg::APB_DW-1:0]  pwdata,
    output logic [ub_pkg::APB_DW-1:0]  prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       relay,
    output logic [1:0]                 motor_cw,
    output logic [1:0]                 motor_ccw,
    output logic                       pwm_0,
    output logic                       pwm_1
);
    import ub_pkg::*;

    logic         btn_clean;
    logic [3:0]   ir_near;
    logic         toggle_req;
    logic         sw_target;
    mode_t        mode;
    ub_style_t    style;
    drive_cmd_t   drive_cmd;
    servo_cmd_t   servo;
    motor_drive_t drive;

    // Mode button filter
    debounce_filter #(.T(logic), .DEB_CYCLES(DEB_CYCLES)) btn_deb_i (
        .clk   (clk),
        .rst   (rst),
        .raw   (mode_btn),
        .clean (btn_clean)
    );

    // IR sensors are active low, filter the near flags
    debounce_filter #(.T(logic [3:0]), .DEB_CYCLES(DEB_CYCLES)) ir_deb_i (
        .clk   (clk),
        .rst   (rst),
        .raw   (~ir_sensor),
        .clean (ir_near)
    );

    mode_fsm mode_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .btn        (btn_clean),
        .toggle_req (toggle_req),
        .sw0        (sw0),
        .mode       (mode),
        .sw_target  (sw_target),
        .relay      (relay)
    );

    apb_regs apb_regs_i (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .mode       (mode),
        .sw_target  (sw_target),
        .style      (style),
        .drive_cmd  (drive_cmd),
        .toggle_req (toggle_req)
    );

    servo_planner servo_planner_i (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .style     (style),
        .sw0       (sw0),
        .sw_target (sw_target),
        .ir_near   (ir_near),
        .dist_0    (dist_0),
        .dist_1    (dist_1),
        .servo     (servo)
    );

    motor_planner motor_planner_i (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .style     (style),
        .drive_cmd (drive_cmd),
        .dist_0    (dist_0),
        .dist_1    (dist_1),
        .drive     (drive)
    );

    servo_pwm #(
        .PWM_PERIOD (PWM_PERIOD),
        .PULSE_MIN  (PULSE_MIN),
        .PULSE_STEP (PULSE_STEP)
    ) servo_pwm_i (
        .clk   (clk),
        .rst   (rst),
        .servo (servo),
        .pwm_0 (pwm_0),
        .pwm_1 (pwm_1)
    );

    // Index 0 is the left motor, 1 the right one
    assign motor_cw[0]  = drive.l_en & drive.l_dir;
    assign motor_ccw[0] = drive.l_en & ~drive.l_dir;
    assign motor_cw[1]  = drive.r_en & drive.r_dir;
    assign motor_ccw[1] = drive.r_en & ~drive.r_dir;

endmodule

//--- bench/tb_ub.sv
/*
 * Useless box controller testbench
 * Random stimulus against a reference model of the mode, servo, motor and relay rules
 */
`timescale 1ns/1ps

module tb_ub;

    localparam int CLK_PERIOD = 100;
    localparam int DEB_CYCLES = 4;
    localparam int PWM_PERIOD = 200;
    // Longest pulse 20 + 31*5 stays inside the short test period
    localparam int PULSE_MIN  = 20;
    localparam int PULSE_STEP = 5;

    localparam int N_APB   = 40;
    localparam int N_RULE  = 4;
    localparam int N_DRIVE = 40;

    // Longest path is IR filter, then planner register
    localparam int SETTLE       = DEB_CYCLES + 6;
    localparam int PRESS_CYCLES = 2 * (DEB_CYCLES + 4) + 2;
    localparam int XFER_CYCLES  = 4;
    localparam int RULE_CYCLES  = SETTLE + 2 * PWM_PERIOD + 2 * XFER_CYCLES + 4;
    localparam int TEST_CYCLES  = 10 + 10 * PRESS_CYCLES + (3 * N_APB + 30) * XFER_CYCLES +
                                  3 * (2 * PRESS_CYCLES + 4 * N_RULE * RULE_CYCLES) +
                                  2 * N_DRIVE * (XFER_CYCLES + 3);
    localparam longint WATCHDOG_NS = longint'(2 * TEST_CYCLES + 500) * CLK_PERIOD;

    localparam logic [3:0] A_STYLE  = 4'h0;
    localparam logic [3:0] A_DRIVE  = 4'h4;
    localparam logic [3:0] A_STATUS = 4'h8;

    localparam logic [1:0] M_NS = 2'd0;
    localparam logic [1:0] M_UB = 2'd1;
    localparam logic [1:0] M_UC = 2'd2;

    localparam int S_CLASSIC = 0;
    localparam int S_DODGE   = 1;
    localparam int S_ADVANCE = 2;
    localparam int S_INVALID = 3;

    logic        clk;
    logic        rst;
    logic        mode_btn;
    logic        sw0;
    logic [3:0]  ir_sensor;
    logic [19:0] dist_0;
    logic [19:0] dist_1;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        relay;
    logic [1:0]  motor_cw;
    logic [1:0]  motor_ccw;
    logic        pwm_0;
    logic        pwm_1;

    integer      seed;
    logic [31:0] rnd;
    logic [3:0]  addr;

    // Reference model state
    logic [1:0]  model_mode;
    logic        model_target;
    logic [2:0]  model_style;
    logic [3:0]  model_drive;

    ub_top #(
        .DEB_CYCLES (DEB_CYCLES),
        .PWM_PERIOD (PWM_PERIOD),
        .PULSE_MIN  (PULSE_MIN),
        .PULSE_STEP (PULSE_STEP)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .mode_btn  (mode_btn),
        .sw0       (sw0),
        .ir_sensor (ir_sensor),
        .dist_0    (dist_0),
        .dist_1    (dist_1),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .relay     (relay),
        .motor_cw  (motor_cw),
        .motor_ccw (motor_ccw),
        .pwm_0     (pwm_0),
        .pwm_1     (pwm_1)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAIL time=%0t signal=%s actual=0x%0h expected=0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    // Ends a run that stops making progress
    initial begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("Watchdog expired after %0d ns, the run did not finish",
                                WATCHDOG_NS));
    end

    function automatic int style_of(input logic [2:0] code);
        case (code)
            3'b001:  return S_CLASSIC;
            3'b010:  return S_DODGE;
            3'b100:  return S_ADVANCE;
            default: return S_INVALID;
        endcase
    endfunction

    function automatic logic [2:0] style_code_for(input int idx);
        case (idx)
            0:       return 3'b001;
            1:       return 3'b010;
            2:       return 3'b100;
            default: return 3'b111;
        endcase
    endfunction

    // Mostly close readings, now and then far away
    function automatic logic [19:0] rand_dist();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] == 4'd0) begin
            return 20'd1000 + 20'(r[19:8]);
        end
        return 20'(r[9:4] % 30);
    endfunction

    // Servo rule, returns {enable, sel, amount}
    function automatic logic [6:0] model_servo(input logic s, input logic [3:0] near,
                                               input logic [19:0] d0, input logic [19:0] d1);
        logic en;
        logic sel;
        int   amt;
        int   d1a;
        int   dmin;
        int   st;
        en   = 1'b0;
        sel  = 1'b0;
        amt  = 0;
        d1a  = int'(d1) + 4;
        dmin = (int'(d0) < d1a) ? int'(d0) : d1a;
        st   = style_of(model_style);
        if (s != model_target) begin
            en  = 1'b1;
            sel = s;
            if (model_mode == M_NS) begin
                sel = ~s;
                amt = 31;
            end else if (model_mode == M_UB && (st == S_CLASSIC || st == S_ADVANCE)) begin
                sel = ~s;
                amt = (|near) ? 0 : 31;
            end
        end else if (model_mode == M_UB) begin
            en  = 1'b1;
            sel = s;
            if (st == S_ADVANCE) begin
                sel = ~s;
                if (|near) begin
                    amt = 31;
                end else if (int'(d0) > 20 && d1a > 20) begin
                    amt = 0;
                end else begin
                    amt = (3 * dmin < 25) ? 3 * dmin : 31;
                end
            end
        end
        return {en, sel, amt[4:0]};
    endfunction

    // Motor rule, returns {l_en, l_dir, r_en, r_dir}
    function automatic logic [3:0] model_motor(input logic [19:0] d0, input logic [19:0] d1);
        int   d1a;
        logic stop;
        logic dir;
        d1a  = int'(d1) + 4;
        stop = (int'(d0) < 7) || (d1a < 7) || (int'(d0) > 10 && d1a > 10);
        dir  = (int'(d0) > d1a) ? 1'b0 : 1'b1;
        if (model_mode == M_UB) begin
            if (style_of(model_style) == S_DODGE && !stop) begin
                return {1'b1, dir, 1'b1, dir};
            end
            return 4'b0000;
        end
        if (model_mode == M_UC) begin
            // fwd, back, left, right
            if (model_drive[3]) return 4'b1111;
            if (model_drive[2]) return 4'b1010;
            if (model_drive[1]) return 4'b0011;
            if (model_drive[0]) return 4'b1100;
        end
        return 4'b0000;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [3:0] a, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic perr);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        waits = 0;
        while (pready !== 1'b1 && waits < 8) begin
            @(negedge clk);
            waits = waits + 1;
        end
        check("pready", pready, 1);
        rdata = prdata;
        perr  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] a, input logic [31:0] data);
        logic [31:0] rdata;
        logic        perr;
        apb_xfer(1'b1, a, data, rdata, perr);
        check($sformatf("pslverr write 0x%0h", a), perr, !(a == A_STYLE || a == A_DRIVE));
        if (a == A_STYLE) begin
            model_style = data[2:0];
        end
        if (a == A_DRIVE) begin
            model_drive = data[3:0];
            // Toggle only counts in NS
            if (data[4] && model_mode == M_NS) begin
                model_target = ~model_target;
            end
        end
    endtask

    task automatic read_and_compare(input logic [3:0] a);
        logic [31:0] rdata;
        logic        perr;
        logic        known;
        logic [31:0] exp;
        known = (a == A_STYLE) || (a == A_DRIVE) || (a == A_STATUS);
        case (a)
            A_STYLE:  exp = {29'b0, model_style};
            A_DRIVE:  exp = {28'b0, model_drive};
            A_STATUS: exp = {29'b0, model_target, model_mode};
            default:  exp = 32'b0;
        endcase
        apb_xfer(1'b0, a, 32'h0, rdata, perr);
        check($sformatf("pslverr read 0x%0h", a), perr, !known);
        if (known) begin
            check($sformatf("prdata 0x%0h", a), rdata, exp);
        end
    endtask

    // Press held for hold cycles, then released long enough to settle
    task automatic press_button(input int hold);
        @(posedge clk);
        mode_btn <= 1'b1;
        repeat (hold) @(posedge clk);
        mode_btn <= 1'b0;
        repeat (DEB_CYCLES + 4) @(posedge clk);
        if (hold > DEB_CYCLES) begin
            model_mode = (model_mode == M_UC) ? M_NS : model_mode + 2'd1;
        end
    endtask

    task automatic goto_mode(input logic [1:0] target);
        while (model_mode != target) begin
            press_button(DEB_CYCLES + 4);
        end
    endtask

    task automatic check_outputs();
        logic [3:0] m;
        @(negedge clk);
        m = model_motor(dist_0, dist_1);
        check("relay", relay, (model_mode == M_NS) ? sw0 : 1'b0);
        check("motor_cw", motor_cw, {m[1] & m[0], m[3] & m[2]});
        check("motor_ccw", motor_ccw, {m[1] & ~m[0], m[3] & ~m[2]});
    endtask

    task automatic measure_pwm(output int hi0, output int hi1);
        hi0 = 0;
        hi1 = 0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            hi0 = hi0 + pwm_0;
            hi1 = hi1 + pwm_1;
        end
    endtask

    task automatic run_rule_case();
        logic [31:0] drv;
        logic [3:0]  ir;
        logic        s;
        logic [19:0] d0;
        logic [19:0] d1;
        logic [6:0]  exp_servo;
        int          hi0;
        int          hi1;
        int          width;
        drv = $random(seed);
        write_reg(A_DRIVE, {27'b0, drv[4:0]});
        s  = drv[8];
        // Half the cases with no hand near
        ir = drv[9] ? 4'hF : drv[13:10];
        d0 = rand_dist();
        d1 = rand_dist();
        @(posedge clk);
        sw0       <= s;
        ir_sensor <= ir;
        dist_0    <= d0;
        dist_1    <= d1;
        repeat (SETTLE) @(posedge clk);
        check_outputs();
        exp_servo = model_servo(s, ~ir, d0, d1);
        // A full period passes so the new command is latched
        repeat (PWM_PERIOD) @(posedge clk);
        measure_pwm(hi0, hi1);
        width = PULSE_MIN + int'(exp_servo[4:0]) * PULSE_STEP;
        check("pwm_0 high time", hi0, (exp_servo[6] && !exp_servo[5]) ? width : 0);
        check("pwm_1 high time", hi1, (exp_servo[6] && exp_servo[5]) ? width : 0);
    endtask

    initial begin
        seed      = 35;
        rst       = 1'b1;
        mode_btn  = 1'b0;
        sw0       = $random(seed);
        ir_sensor = 4'hF;
        dist_0    = 20'd100;
        dist_1    = 20'd100;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 4'h0;
        pwdata    = 32'h0;

        model_mode   = M_NS;
        model_target = sw0;
        model_style  = 3'b000;
        model_drive  = 4'b0000;

        // Outputs quiet while reset is held
        repeat (9) @(posedge clk);
        @(negedge clk);
        check("relay in reset", relay, 0);
        check("motor_cw in reset", motor_cw, 0);
        check("motor_ccw in reset", motor_ccw, 0);
        check("pwm in reset", {pwm_1, pwm_0}, 0);
        @(posedge clk);
        rst <= 1'b0;

        read_and_compare(A_STATUS);
        read_and_compare(A_STYLE);
        read_and_compare(A_DRIVE);
        check_outputs();

        // Mode ring with a short glitch in between
        press_button(DEB_CYCLES + 4);
        read_and_compare(A_STATUS);
        press_button(2);
        read_and_compare(A_STATUS);
        press_button(DEB_CYCLES + 4);
        read_and_compare(A_STATUS);
        press_button(DEB_CYCLES + 4);
        read_and_compare(A_STATUS);

        // Register traffic, toggles land while in NS
        repeat (N_APB) begin
            rnd  = $random(seed);
            addr = rnd[31] ? A_STYLE : A_DRIVE;
            write_reg(addr, {rnd[30:0], rnd[31]});
            read_and_compare(addr);
            if (rnd[7:6] == 2'b00) begin
                read_and_compare(A_STATUS);
            end
        end
        write_reg(A_STATUS, $random(seed));
        for (int a = 0; a < 16; a++) begin
            if (a != A_STYLE && a != A_DRIVE && a != A_STATUS) begin
                read_and_compare(4'(a));
                write_reg(4'(a), $random(seed));
            end
        end
        read_and_compare(A_STYLE);
        read_and_compare(A_DRIVE);

        goto_mode(M_NS);
        write_reg(A_DRIVE, 32'h10);
        read_and_compare(A_STATUS);
        goto_mode(M_UB);
        write_reg(A_DRIVE, 32'h10);
        read_and_compare(A_STATUS);

        // Servo, relay and motor rules across modes and styles
        for (int m = 0; m < 3; m++) begin
            goto_mode(2'(m));
            for (int si = 0; si < 4; si++) begin
                write_reg(A_STYLE, {29'b0, style_code_for(si)});
                repeat (N_RULE) run_rule_case();
            end
        end

        // Dodge driving from random ranges
        goto_mode(M_UB);
        write_reg(A_STYLE, 32'h2);
        repeat (N_DRIVE) begin
            @(posedge clk);
            dist_0 <= rand_dist();
            dist_1 <= rand_dist();
            repeat (3) @(posedge clk);
            check_outputs();
        end

        // Remote car commands
        goto_mode(M_UC);
        repeat (N_DRIVE) begin
            rnd = $random(seed);
            write_reg(A_DRIVE, {27'b0, rnd[4:0]});
            repeat (2) @(posedge clk);
            check_outputs();
        end
        read_and_compare(A_STATUS);

        $display("test passed");
        $finish;
    end

endmodule

//--- filelist.f
src/ub_pkg.sv
src/debounce_filter.sv
src/mode_fsm.sv
src/apb_regs.sv
src/servo_planner.sv
src/motor_planner.sv
src/servo_pwm.sv
src/ub_top.sv
bench/tb_ub.sv
